// File: bus_subsystem.f
bus_pkg.sv
bus_arbiter.sv
bus_uart.sv
bus_clint.sv
bus_subsystem.sv
tb_mem_model.sv
tb_bus_subsystem.sv

// File: run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f bus_subsystem.f \
  --top-module tb_bus_subsystem -o sim_bus
./obj_dir/sim_bus > sim.log
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
grep -q "Simulation PASSED" sim.log

// File: tb_bus_subsystem.sv
`default_nettype none

module tb_bus_subsystem import bus_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  // 13 accesses of at most 20 cycles each, plus reset, with wide margin
  localparam int MAX_CYCLES = 2000;

  logic clk, rst;
  logic [ADDR_W-1:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i;
  logic ifu_arvalid_i, ifu_rready_i, lsu_arvalid_i, lsu_rready_i;
  logic lsu_awvalid_i, lsu_wvalid_i, lsu_bready_i;
  logic [DATA_W-1:0] lsu_wdata_i;
  logic [STRB_W-1:0] lsu_wstrb_i;
  wire ifu_arready_o, ifu_rvalid_o, lsu_arready_o, lsu_rvalid_o;
  wire lsu_awready_o, lsu_wready_o, lsu_bvalid_o;
  wire [DATA_W-1:0] ifu_rdata_o, lsu_rdata_o;
  wire [RESP_W-1:0] ifu_rresp_o, lsu_rresp_o, lsu_bresp_o;
  wire [ADDR_W-1:0] mem_araddr_o, mem_awaddr_o;
  wire mem_arvalid_o, mem_arready_i, mem_rvalid_i, mem_rready_o;
  wire mem_awvalid_o, mem_awready_i, mem_wvalid_o, mem_wready_i;
  wire mem_bvalid_i, mem_bready_o;
  wire [DATA_W-1:0] mem_rdata_i, mem_wdata_o;
  wire [STRB_W-1:0] mem_wstrb_o;
  wire [RESP_W-1:0] mem_rresp_i, mem_bresp_i;
  wire [7:0] tx_data_o;
  wire tx_valid_o;
  int  write_count;

  int cycles, since_rst, tx_pulses;
  int errors, tx_errs, lock_errs, quiet_errs, ntests, nfailed;
  bit quiet;
  logic [7:0] tx_last;

  bus_subsystem dut_i (.*);

  tb_mem_model mem_i (
    .clk(clk), .rst(rst),
    .araddr_i(mem_araddr_o), .arvalid_i(mem_arvalid_o), .arready_o(mem_arready_i),
    .rdata_o(mem_rdata_i), .rresp_o(mem_rresp_i), .rvalid_o(mem_rvalid_i),
    .rready_i(mem_rready_o),
    .awaddr_i(mem_awaddr_o), .awvalid_i(mem_awvalid_o), .awready_o(mem_awready_i),
    .wdata_i(mem_wdata_o), .wstrb_i(mem_wstrb_o), .wvalid_i(mem_wvalid_o),
    .wready_o(mem_wready_i),
    .bresp_o(mem_bresp_i), .bvalid_o(mem_bvalid_i), .bready_i(mem_bready_o),
    .write_count_o(write_count)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (!rst) since_rst++;
    if (tx_valid_o) begin
      tx_pulses++;
      tx_last = tx_data_o;
    end
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // nothing may be valid after reset before the first request
  always @(posedge clk) begin
    if (quiet && !rst) begin
      assert (!(ifu_rvalid_o || lsu_rvalid_o || lsu_bvalid_o || mem_arvalid_o ||
                mem_awvalid_o || mem_wvalid_o || tx_valid_o))
      else begin
        $display("a valid output was high before any request");
        quiet_errs++;
      end
    end
  end

  tx_single_pulse: assert property (@(posedge clk) disable iff (rst)
    tx_valid_o |=> !tx_valid_o)
  else begin
    $display("tx_valid_o stayed high for more than one cycle");
    tx_errs++;
  end

  fetch_locked_out: assert property (@(posedge clk) disable iff (rst)
    (lsu_rvalid_o && !lsu_rready_i) |-> !ifu_arready_o)
  else begin
    $display("fetch was granted while a load response was still pending");
    lock_errs++;
  end

  function automatic int error_total();
    return errors + tx_errs + lock_errs + quiet_errs;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) r[8*k +: 8] = data[8*k +: 8];
    end
    return r;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    ntests++;
    if (error_total() != errs_before) nfailed++;
    $display("test %-22s %s", name, (error_total() == errs_before) ? "ok" : "failed");
  endtask

  // t is the cycle count of the response beat, taken once it has settled
  task automatic fetch_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, output int t);
    @(negedge clk);
    quiet = 0;
    ifu_araddr_i = addr;
    ifu_arvalid_i = 1;
    ifu_rready_i = 1;
    do @(posedge clk); while (!ifu_arready_o);
    @(negedge clk);
    ifu_arvalid_i = 0;
    do @(posedge clk); while (!ifu_rvalid_o);
    data = ifu_rdata_o;
    resp = ifu_rresp_o;
    @(negedge clk);
    t = cycles;
  endtask

  // hold keeps rready low for that many cycles after rvalid
  task automatic load_read(input logic [31:0] addr, input int hold, output logic [31:0] data,
                           output logic [1:0] resp, output int t);
    @(negedge clk);
    quiet = 0;
    lsu_araddr_i = addr;
    lsu_arvalid_i = 1;
    lsu_rready_i = (hold == 0);
    do @(posedge clk); while (!lsu_arready_o);
    @(negedge clk);
    lsu_arvalid_i = 0;
    do @(posedge clk); while (!lsu_rvalid_o);
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      @(negedge clk);
      lsu_rready_i = 1;
      @(posedge clk);
    end
    data = lsu_rdata_o;
    resp = lsu_rresp_o;
    @(negedge clk);
    lsu_rready_i = 0;
    t = cycles;
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, output logic [1:0] resp);
    bit aw_ok;
    bit w_ok;
    aw_ok = 0;
    w_ok = 0;
    @(negedge clk);
    quiet = 0;
    lsu_awaddr_i = addr;
    lsu_wdata_i = data;
    lsu_wstrb_i = strb;
    lsu_awvalid_i = 1;
    lsu_wvalid_i = 1;
    while (!(aw_ok && w_ok)) begin
      @(posedge clk);
      if (lsu_awready_o) aw_ok = 1;
      if (lsu_wready_o) w_ok = 1;
    end
    @(negedge clk);
    lsu_awvalid_i = 0;
    lsu_wvalid_i = 0;
    lsu_bready_i = 1;
    do @(posedge clk); while (!lsu_bvalid_o);
    resp = lsu_bresp_o;
    @(negedge clk);
    lsu_bready_i = 0;
  endtask

  initial begin
    logic [31:0] d1, d2;
    logic [1:0]  r1, r2;
    int t1, t2, e0, wc0, tx0;
    clk = 0;
    rst = 1;
    quiet = 1;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 0;
    ifu_rready_i = 0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 0;
    lsu_rready_i = 0;
    lsu_awaddr_i = '0;
    lsu_awvalid_i = 0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_wvalid_i = 0;
    lsu_bready_i = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 0;

    e0 = error_total();
    repeat (4) @(negedge clk);
    end_test("reset", e0);

    e0 = error_total();
    fetch_read(32'h40, d1, r1, t1);
    expect_eq("ifu_rdata_o", d1, 32'h40 ^ 32'hA5A5_0000);
    expect_eq("ifu_rresp_o", 32'(r1), 32'(RESP_OKAY));
    end_test("fetch read", e0);

    e0 = error_total();
    store(32'h80, 32'h1122_3344, 4'b0101, r1);
    expect_eq("lsu_bresp_o", 32'(r1), 32'(RESP_OKAY));
    load_read(32'h80, 0, d1, r1, t1);
    expect_eq("lsu_rdata_o", d1, merge_bytes(32'h80 ^ 32'hA5A5_0000, 32'h1122_3344, 4'b0101));
    expect_eq("lsu_rresp_o", 32'(r1), 32'(RESP_OKAY));
    end_test("store then load", e0);

    e0 = error_total();
    wc0 = write_count;
    tx0 = tx_pulses;
    store(SERIAL_ADDR, 32'hCAFE_F05A, 4'b1111, r1);
    repeat (2) @(posedge clk);
    expect_eq("lsu_bresp_o", 32'(r1), 32'(RESP_OKAY));
    expect_eq("tx pulses", 32'(tx_pulses - tx0), 32'd1);
    expect_eq("tx_data_o", 32'(tx_last), 32'h5A);
    store(SERIAL_ADDR, 32'h0000_7700, 4'b0010, r1);
    repeat (2) @(posedge clk);
    expect_eq("lsu_bresp_o", 32'(r1), 32'(RESP_SLVERR));
    expect_eq("tx pulses", 32'(tx_pulses - tx0), 32'd1);
    expect_eq("write count", 32'(write_count), 32'(wc0));
    end_test("serial port store", e0);

    e0 = error_total();
    load_read(CLINT_MTIME_LO, 0, d1, r1, t1);
    expect_eq("lsu_rresp_o", 32'(r1), 32'(RESP_OKAY));
    load_read(CLINT_MTIME_LO, 0, d2, r2, t2);
    assert (d2 > d1 && d2 < 32'(since_rst))
    else begin
      $display("** Error: lsu_rdata_o = %h, expected above %h and below %h",
               d2, d1, since_rst);
      errors++;
    end
    load_read(CLINT_MTIME_HI, 0, d1, r1, t1);
    expect_eq("lsu_rdata_o", d1, 32'h0);
    load_read(32'h0200_0000, 0, d1, r1, t1);
    expect_eq("lsu_rresp_o", 32'(r1), 32'(RESP_SLVERR));
    end_test("timer reads", e0);

    e0 = error_total();
    fork
      fetch_read(32'h10, d1, r1, t1);
      load_read(32'h20, 0, d2, r2, t2);
    join
    expect_eq("ifu_rdata_o", d1, 32'h10 ^ 32'hA5A5_0000);
    expect_eq("lsu_rdata_o", d2, 32'h20 ^ 32'hA5A5_0000);
    assert (t1 < t2)
    else begin
      $display("load was answered before the fetch raised in the same cycle");
      errors++;
    end
    // fetch asks while a timer load response is held back
    // memory itself stays free, so only the owner lock keeps fetch out
    fork
      load_read(CLINT_MTIME_HI, 6, d2, r2, t2);
      begin
        do @(posedge clk); while (!lsu_rvalid_o);
        fetch_read(32'h34, d1, r1, t1);
      end
    join
    expect_eq("lsu_rdata_o", d2, 32'h0);
    expect_eq("lsu_rresp_o", 32'(r2), 32'(RESP_OKAY));
    expect_eq("ifu_rdata_o", d1, 32'h34 ^ 32'hA5A5_0000);
    assert (t2 < t1)
    else begin
      $display("fetch overtook a granted load");
      errors++;
    end
    end_test("simultaneous reads", e0);

    repeat (2) @(negedge clk);
    $display("tests %0d, failed %0d, errors %0d", ntests, nfailed, error_total());
    if (error_total() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

module tb_mem_model import bus_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  input  wire  [ADDR_W-1:0] araddr_i,
  input  wire               arvalid_i,
  output logic              arready_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic [RESP_W-1:0] rresp_o,
  output logic              rvalid_o,
  input  wire               rready_i,
  input  wire  [ADDR_W-1:0] awaddr_i,
  input  wire               awvalid_i,
  output logic              awready_o,
  input  wire  [DATA_W-1:0] wdata_i,
  input  wire  [STRB_W-1:0] wstrb_i,
  input  wire               wvalid_i,
  output logic              wready_o,
  output logic [RESP_W-1:0] bresp_o,
  output logic              bvalid_o,
  input  wire               bready_i,
  output int                write_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] mem [256];
  logic [15:0]       lfsr;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  // handshakes and requests seen at the last rising edge
  logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic ar_req, aw_req, w_req;
  bit   r_pend, aw_have, w_have, b_pend;
  int   ar_cnt, ar_dly, r_cnt, r_dly, aw_cnt, aw_dly, w_cnt, w_dly, b_cnt, b_dly;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // two bits per delay, 0 to 3 cycles
  task automatic draw_delay(output int d);
    d = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
  endtask

  initial begin
    lfsr = 16'd63;
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
    end
  end

  always @(posedge clk) begin
    ar_hs  = arvalid_i && arready_o;
    r_hs   = rvalid_o && rready_i;
    aw_hs  = awvalid_i && awready_o;
    w_hs   = wvalid_i && wready_o;
    b_hs   = bvalid_o && bready_i;
    ar_req = arvalid_i && !arready_o;
    aw_req = awvalid_i && !awready_o;
    w_req  = wvalid_i && !wready_o;
    if (ar_hs) rd_addr = araddr_i;
    if (aw_hs) wr_addr = awaddr_i;
    if (w_hs) begin
      wr_data = wdata_i;
      wr_strb = wstrb_i;
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    if (rst) begin
      arready_o = 0; rvalid_o = 0; awready_o = 0; wready_o = 0; bvalid_o = 0;
      rdata_o = '0; rresp_o = RESP_OKAY; bresp_o = RESP_OKAY;
      r_pend = 0; aw_have = 0; w_have = 0; b_pend = 0; write_count_o = 0;
      ar_cnt = 0; aw_cnt = 0; w_cnt = 0;
      draw_delay(ar_dly);
      draw_delay(aw_dly);
      draw_delay(w_dly);
    end else begin
      // read address and data
      if (ar_hs) begin
        arready_o = 0; r_pend = 1; r_cnt = 0; ar_cnt = 0;
        draw_delay(r_dly);
        draw_delay(ar_dly);
      end else if (ar_req && !r_pend) begin
        if (ar_cnt >= ar_dly) arready_o = 1;
        else ar_cnt++;
      end else begin
        arready_o = 0;
      end
      if (r_hs) begin
        rvalid_o = 0;
        r_pend = 0;
      end else if (r_pend && !rvalid_o) begin
        if (r_cnt >= r_dly) begin
          rvalid_o = 1;
          rdata_o  = mem[rd_addr[9:2]];
          rresp_o  = RESP_OKAY;
        end else begin
          r_cnt++;
        end
      end
      // write address and data may be taken in different cycles
      if (aw_hs) begin
        awready_o = 0; aw_have = 1; aw_cnt = 0;
        draw_delay(aw_dly);
      end else if (aw_req && !aw_have && !b_pend) begin
        if (aw_cnt >= aw_dly) awready_o = 1;
        else aw_cnt++;
      end
      if (w_hs) begin
        wready_o = 0; w_have = 1; w_cnt = 0;
        draw_delay(w_dly);
      end else if (w_req && !w_have && !b_pend) begin
        if (w_cnt >= w_dly) wready_o = 1;
        else w_cnt++;
      end
      if (aw_have && w_have && !b_pend) begin
        for (int k = 0; k < STRB_W; k++) begin
          if (wr_strb[k]) mem[wr_addr[9:2]][8*k +: 8] = wr_data[8*k +: 8];
        end
        write_count_o++;
        aw_have = 0; w_have = 0; b_pend = 1; b_cnt = 0;
        draw_delay(b_dly);
      end
      if (b_hs) begin
        bvalid_o = 0;
        b_pend = 0;
      end else if (b_pend && !bvalid_o) begin
        if (b_cnt >= b_dly) begin
          bvalid_o = 1;
          bresp_o  = RESP_OKAY;
        end else begin
          b_cnt++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bus_subsystem.sv
`default_nettype none

module bus_subsystem import bus_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  // fetch read
  input  wire  [ADDR_W-1:0] ifu_araddr_i,
  input  wire               ifu_arvalid_i,
  output wire               ifu_arready_o,
  output wire  [DATA_W-1:0] ifu_rdata_o,
  output wire  [RESP_W-1:0] ifu_rresp_o,
  output wire               ifu_rvalid_o,
  input  wire               ifu_rready_i,
  // load
  input  wire  [ADDR_W-1:0] lsu_araddr_i,
  input  wire               lsu_arvalid_i,
  output wire               lsu_arready_o,
  output wire  [DATA_W-1:0] lsu_rdata_o,
  output wire  [RESP_W-1:0] lsu_rresp_o,
  output wire               lsu_rvalid_o,
  input  wire               lsu_rready_i,
  // store
  input  wire  [ADDR_W-1:0] lsu_awaddr_i,
  input  wire               lsu_awvalid_i,
  output wire               lsu_awready_o,
  input  wire  [DATA_W-1:0] lsu_wdata_i,
  input  wire  [STRB_W-1:0] lsu_wstrb_i,
  input  wire               lsu_wvalid_i,
  output wire               lsu_wready_o,
  output wire  [RESP_W-1:0] lsu_bresp_o,
  output wire               lsu_bvalid_o,
  input  wire               lsu_bready_i,
  // external memory
  output wire  [ADDR_W-1:0] mem_araddr_o,
  output wire               mem_arvalid_o,
  input  wire               mem_arready_i,
  input  wire  [DATA_W-1:0] mem_rdata_i,
  input  wire  [RESP_W-1:0] mem_rresp_i,
  input  wire               mem_rvalid_i,
  output wire               mem_rready_o,
  output wire  [ADDR_W-1:0] mem_awaddr_o,
  output wire               mem_awvalid_o,
  input  wire               mem_awready_i,
  output wire  [DATA_W-1:0] mem_wdata_o,
  output wire  [STRB_W-1:0] mem_wstrb_o,
  output wire               mem_wvalid_o,
  input  wire               mem_wready_i,
  input  wire  [RESP_W-1:0] mem_bresp_i,
  input  wire               mem_bvalid_i,
  output wire               mem_bready_o,
  // serial output
  output wire  [7:0]        tx_data_o,
  output wire               tx_valid_o
);

  // timer link
  wire [ADDR_W-1:0] clint_araddr;
  wire              clint_arvalid;
  wire              clint_arready;
  wire [DATA_W-1:0] clint_rdata;
  wire [RESP_W-1:0] clint_rresp;
  wire              clint_rvalid;
  wire              clint_rready;

  // serial port link
  wire              uart_awvalid;
  wire              uart_wvalid;
  wire [DATA_W-1:0] uart_wdata;
  wire [STRB_W-1:0] uart_wstrb;
  wire              uart_awready;
  wire              uart_wready;
  wire [RESP_W-1:0] uart_bresp;
  wire              uart_bvalid;
  wire              uart_bready;

  // requester and memory ports share names with the top level
  bus_arbiter arbiter_i (
    .clint_araddr_o  (clint_araddr),
    .clint_arvalid_o (clint_arvalid),
    .clint_arready_i (clint_arready),
    .clint_rdata_i   (clint_rdata),
    .clint_rresp_i   (clint_rresp),
    .clint_rvalid_i  (clint_rvalid),
    .clint_rready_o  (clint_rready),
    .uart_awvalid_o  (uart_awvalid),
    .uart_wvalid_o   (uart_wvalid),
    .uart_wdata_o    (uart_wdata),
    .uart_wstrb_o    (uart_wstrb),
    .uart_awready_i  (uart_awready),
    .uart_wready_i   (uart_wready),
    .uart_bresp_i    (uart_bresp),
    .uart_bvalid_i   (uart_bvalid),
    .uart_bready_o   (uart_bready),
    .*
  );

  bus_clint clint_i (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (clint_araddr),
    .arvalid_i (clint_arvalid),
    .arready_o (clint_arready),
    .rdata_o   (clint_rdata),
    .rresp_o   (clint_rresp),
    .rvalid_o  (clint_rvalid),
    .rready_i  (clint_rready)
  );

  bus_uart uart_i (
    .clk        (clk),
    .rst        (rst),
    .awvalid_i  (uart_awvalid),
    .awready_o  (uart_awready),
    .wdata_i    (uart_wdata),
    .wstrb_i    (uart_wstrb),
    .wvalid_i   (uart_wvalid),
    .wready_o   (uart_wready),
    .bresp_o    (uart_bresp),
    .bvalid_o   (uart_bvalid),
    .bready_i   (uart_bready),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o)
  );

endmodule

`default_nettype wire

// File: bus_clint.sv
`default_nettype none

module bus_clint import bus_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  input  wire  [ADDR_W-1:0] araddr_i,
  input  wire               arvalid_i,
  output logic              arready_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic [RESP_W-1:0] rresp_o,
  output logic              rvalid_o,
  input  wire               rready_i
);

  logic [MTIME_W-1:0] mtime_q;
  logic               rvalid_q;
  logic [DATA_W-1:0]  rdata_q;
  logic [RESP_W-1:0]  rresp_q;
  logic               ar_hs;
  logic               addr_ok;

  assign arready_o = !rvalid_q;
  assign ar_hs     = arvalid_i && arready_o;
  assign addr_ok   = (araddr_i == CLINT_MTIME_LO) || (araddr_i == CLINT_MTIME_HI);

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

  // free-running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // bit 2 picks the high word
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= araddr_i[2] ? mtime_q[MTIME_W-1:DATA_W] : mtime_q[DATA_W-1:0];
      rresp_q <= addr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

// File: bus_uart.sv
`default_nettype none

module bus_uart import bus_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  input  wire               awvalid_i,
  output logic              awready_o,
  input  wire  [DATA_W-1:0] wdata_i,
  input  wire  [STRB_W-1:0] wstrb_i,
  input  wire               wvalid_i,
  output logic              wready_o,
  output logic [RESP_W-1:0] bresp_o,
  output logic              bvalid_o,
  input  wire               bready_i,
  output logic [7:0]        tx_data_o,
  output logic              tx_valid_o
);

  logic              accept;
  logic              bvalid_q;
  logic [RESP_W-1:0] bresp_q;
  logic              tx_valid_q;
  logic [7:0]        tx_data_q;

  // address and data are taken together, one store at a time
  assign accept    = awvalid_i && wvalid_i && !bvalid_q;
  assign awready_o = accept;
  assign wready_o  = accept;

  assign bvalid_o   = bvalid_q;
  assign bresp_o    = bresp_q;
  assign tx_valid_o = tx_valid_q;
  assign tx_data_o  = tx_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid_q   <= 1'b0;
      tx_valid_q <= 1'b0;
    end else begin
      // strobe lasts a single cycle
      tx_valid_q <= accept && wstrb_i[0];
      if (accept) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tx_data_q <= wdata_i[7:0];
      // no byte 0 means nothing to send
      bresp_q   <= wstrb_i[0] ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter import bus_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  // fetch read
  input  wire  [ADDR_W-1:0] ifu_araddr_i,
  input  wire               ifu_arvalid_i,
  output logic              ifu_arready_o,
  output logic [DATA_W-1:0] ifu_rdata_o,
  output logic [RESP_W-1:0] ifu_rresp_o,
  output logic              ifu_rvalid_o,
  input  wire               ifu_rready_i,
  // load
  input  wire  [ADDR_W-1:0] lsu_araddr_i,
  input  wire               lsu_arvalid_i,
  output logic              lsu_arready_o,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic [RESP_W-1:0] lsu_rresp_o,
  output logic              lsu_rvalid_o,
  input  wire               lsu_rready_i,
  // store
  input  wire  [ADDR_W-1:0] lsu_awaddr_i,
  input  wire               lsu_awvalid_i,
  output logic              lsu_awready_o,
  input  wire  [DATA_W-1:0] lsu_wdata_i,
  input  wire  [STRB_W-1:0] lsu_wstrb_i,
  input  wire               lsu_wvalid_i,
  output logic              lsu_wready_o,
  output logic [RESP_W-1:0] lsu_bresp_o,
  output logic              lsu_bvalid_o,
  input  wire               lsu_bready_i,
  // external memory
  output logic [ADDR_W-1:0] mem_araddr_o,
  output logic              mem_arvalid_o,
  input  wire               mem_arready_i,
  input  wire  [DATA_W-1:0] mem_rdata_i,
  input  wire  [RESP_W-1:0] mem_rresp_i,
  input  wire               mem_rvalid_i,
  output logic              mem_rready_o,
  output logic [ADDR_W-1:0] mem_awaddr_o,
  output logic              mem_awvalid_o,
  input  wire               mem_awready_i,
  output logic [DATA_W-1:0] mem_wdata_o,
  output logic [STRB_W-1:0] mem_wstrb_o,
  output logic              mem_wvalid_o,
  input  wire               mem_wready_i,
  input  wire  [RESP_W-1:0] mem_bresp_i,
  input  wire               mem_bvalid_i,
  output logic              mem_bready_o,
  // timer
  output logic [ADDR_W-1:0] clint_araddr_o,
  output logic              clint_arvalid_o,
  input  wire               clint_arready_i,
  input  wire  [DATA_W-1:0] clint_rdata_i,
  input  wire  [RESP_W-1:0] clint_rresp_i,
  input  wire               clint_rvalid_i,
  output logic              clint_rready_o,
  // serial port
  output logic              uart_awvalid_o,
  output logic              uart_wvalid_o,
  output logic [DATA_W-1:0] uart_wdata_o,
  output logic [STRB_W-1:0] uart_wstrb_o,
  input  wire               uart_awready_i,
  input  wire               uart_wready_i,
  input  wire  [RESP_W-1:0] uart_bresp_i,
  input  wire               uart_bvalid_i,
  output logic              uart_bready_o
);

  logic [1:0] own_q;
  logic [1:0] wt_q;
  logic       aw_done_q;
  logic       w_done_q;

  logic       lsu_rd_clint;
  logic       lsu_wr_uart;
  logic       ar_free;
  logic       wr_free;
  logic       ifu_go;
  logic       lsu_go;
  logic       ifu_ar_hs;
  logic       lsu_ar_hs;
  logic       ifu_r_hs;
  logic       lsu_r_hs;
  logic       mem_aw_hs;
  logic       mem_w_hs;
  logic       aw_done;
  logic       w_done;
  logic       uart_hs;
  logic       b_hs;

  // address decode
  assign lsu_rd_clint = lsu_araddr_i[ADDR_W-1:CLINT_DEC_LSB] ==
                        CLINT_BASE[ADDR_W-1:CLINT_DEC_LSB];
  assign lsu_wr_uart  = lsu_awaddr_i == SERIAL_ADDR;

  // read grant, fetch has priority while no read is in flight
  assign ar_free = own_q == OWN_IDLE;
  assign ifu_go  = ar_free && ifu_arvalid_i;
  assign lsu_go  = ar_free && !ifu_arvalid_i && lsu_arvalid_i;

  assign mem_araddr_o    = ifu_arvalid_i ? ifu_araddr_i : lsu_araddr_i;
  assign mem_arvalid_o   = ifu_go || (lsu_go && !lsu_rd_clint);
  assign clint_araddr_o  = lsu_araddr_i;
  assign clint_arvalid_o = lsu_go && lsu_rd_clint;

  assign ifu_arready_o = ifu_go && mem_arready_i;
  assign lsu_arready_o = lsu_go && (lsu_rd_clint ? clint_arready_i : mem_arready_i);

  // responses only reach the recorded owner
  assign mem_rready_o   = ((own_q == OWN_IFU) && ifu_rready_i) ||
                          ((own_q == OWN_LSU_MEM) && lsu_rready_i);
  assign clint_rready_o = (own_q == OWN_LSU_CLINT) && lsu_rready_i;

  assign ifu_rdata_o  = mem_rdata_i;
  assign ifu_rresp_o  = mem_rresp_i;
  assign ifu_rvalid_o = (own_q == OWN_IFU) && mem_rvalid_i;

  assign lsu_rdata_o  = (own_q == OWN_LSU_CLINT) ? clint_rdata_i : mem_rdata_i;
  assign lsu_rresp_o  = (own_q == OWN_LSU_CLINT) ? clint_rresp_i : mem_rresp_i;
  assign lsu_rvalid_o = ((own_q == OWN_LSU_MEM) && mem_rvalid_i) ||
                        ((own_q == OWN_LSU_CLINT) && clint_rvalid_i);

  assign ifu_ar_hs = ifu_arvalid_i && ifu_arready_o;
  assign lsu_ar_hs = lsu_arvalid_i && lsu_arready_o;
  assign ifu_r_hs  = ifu_rvalid_o && ifu_rready_i;
  assign lsu_r_hs  = lsu_rvalid_o && lsu_rready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      own_q <= OWN_IDLE;
    end else if (ifu_ar_hs) begin
      own_q <= OWN_IFU;
    end else if (lsu_ar_hs) begin
      own_q <= lsu_rd_clint ? OWN_LSU_CLINT : OWN_LSU_MEM;
    end else if (ifu_r_hs || lsu_r_hs) begin
      own_q <= OWN_IDLE;
    end
  end

  // write path, memory aw and w may be accepted in different cycles
  assign wr_free = wt_q == WT_IDLE;

  assign mem_awaddr_o  = lsu_awaddr_i;
  assign mem_wdata_o   = lsu_wdata_i;
  assign mem_wstrb_o   = lsu_wstrb_i;
  assign mem_awvalid_o = wr_free && !lsu_wr_uart && lsu_awvalid_i && !aw_done_q;
  assign mem_wvalid_o  = wr_free && !lsu_wr_uart && lsu_wvalid_i && !w_done_q;

  assign uart_wdata_o   = lsu_wdata_i;
  assign uart_wstrb_o   = lsu_wstrb_i;
  assign uart_awvalid_o = wr_free && lsu_wr_uart && lsu_awvalid_i;
  assign uart_wvalid_o  = wr_free && lsu_wr_uart && lsu_wvalid_i;

  assign mem_aw_hs = mem_awvalid_o && mem_awready_i;
  assign mem_w_hs  = mem_wvalid_o && mem_wready_i;
  assign aw_done   = aw_done_q || mem_aw_hs;
  assign w_done    = w_done_q || mem_w_hs;
  assign uart_hs   = uart_awvalid_o && uart_awready_i && uart_wvalid_o && uart_wready_i;

  assign lsu_awready_o = mem_aw_hs || (uart_awvalid_o && uart_awready_i);
  assign lsu_wready_o  = mem_w_hs || (uart_wvalid_o && uart_wready_i);

  assign mem_bready_o  = (wt_q == WT_MEM) && lsu_bready_i;
  assign uart_bready_o = (wt_q == WT_UART) && lsu_bready_i;
  assign lsu_bresp_o   = (wt_q == WT_UART) ? uart_bresp_i : mem_bresp_i;
  assign lsu_bvalid_o  = ((wt_q == WT_MEM) && mem_bvalid_i) ||
                         ((wt_q == WT_UART) && uart_bvalid_i);

  assign b_hs = lsu_bvalid_o && lsu_bready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      wt_q      <= WT_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      if (uart_hs) begin
        wt_q <= WT_UART;
      end else if (aw_done && w_done) begin
        wt_q <= WT_MEM;
      end else if (b_hs) begin
        wt_q <= WT_IDLE;
      end
      // remember a half-accepted store until the other half goes
      aw_done_q <= aw_done && !w_done;
      w_done_q  <= w_done && !aw_done;
    end
  end

endmodule

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  // response codes, AXI encoding
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  // serial port takes stores at one address only
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'h1000_0000;

  // timer window is decoded on the upper address bits
  localparam logic [ADDR_W-1:0] CLINT_BASE     = 32'h0200_0000;
  localparam int                CLINT_DEC_LSB  = 16;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 32'h0200_BFFC;
  localparam int                MTIME_W        = 64;

  // read owner codes
  localparam logic [1:0] OWN_IDLE      = 2'd0;
  localparam logic [1:0] OWN_IFU       = 2'd1;
  localparam logic [1:0] OWN_LSU_MEM   = 2'd2;
  localparam logic [1:0] OWN_LSU_CLINT = 2'd3;

  // write target codes
  localparam logic [1:0] WT_IDLE = 2'd0;
  localparam logic [1:0] WT_MEM  = 2'd1;
  localparam logic [1:0] WT_UART = 2'd2;

endpackage

`default_nettype wire
